// ==== hw/eth_uplink_config.svh ====
//----------------------------
// uplink build parameters
// port count, widths, cut lengths and buffer sizes
//----------------------------
`ifndef ETH_UPLINK_CONFIG_SVH
`define ETH_UPLINK_CONFIG_SVH

// port side
`define ETH_COUNT   4       // ethernet ports on the board
`define BYTE_W      8       // stream byte width

// framing, bytes removed by each cutter
`define HDR_BYTES   8       // preamble + sfd
`define FCS_BYTES   4       // crc32 trailer

// uplink side
`define FIFO_DEPTH  64      // frame buffer entries
`define CREDIT_MAX  16      // credits above this are dropped

`endif

// ==== hw/eth_uplink_pkg.sv ====
//----------------------------
// uplink shared types
//----------------------------
`include "eth_uplink_config.svh"

package eth_uplink_pkg;

    localparam int PORT_W = (`ETH_COUNT > 1) ? $clog2(`ETH_COUNT) : 1;

    typedef logic [`BYTE_W-1:0] byte_t;
    typedef logic [PORT_W-1:0]  port_t;     // eth_num style port index

    // port selector
    typedef enum logic [1:0] {
        SEL_IDLE = 2'd0,    // waiting for a sof
        SEL_PASS = 2'd1,    // forwarding the locked port
        SEL_DROP = 2'd2     // swallowing a frame while disabled
    } sel_state_t;

    // payload cutter
    typedef enum logic [1:0] {
        CUT_IDLE = 2'd0,
        CUT_HEAD = 2'd1,    // preamble/sfd bytes
        CUT_BODY = 2'd2     // payload + fcs
    } cut_state_t;

endpackage

// ==== hw/frame_stream_if.sv ====
//----------------------------
// frame byte stream
// one byte per valid, no back-pressure
//----------------------------
`timescale 1ns/1ps

interface frame_stream_if import eth_uplink_pkg::*; ();

    byte_t  data;
    logic   valid;
    logic   sof;    // first byte of frame
    logic   eof;    // last byte of frame

    // producer side
    modport src (
        output data,
        output valid,
        output sof,
        output eof
    );

    // consumer side
    modport snk (
        input  data,
        input  valid,
        input  sof,
        input  eof
    );

endinterface

// ==== hw/rx_payload_cut.sv ====
//----------------------------
// rx payload cutter
// strips preamble/sfd and fcs from one port
//----------------------------
`timescale 1ns/1ps
`include "eth_uplink_config.svh"

module rx_payload_cut import eth_uplink_pkg::*; (
    input  logic        clk125M,
    input  logic        rst_i,
    input  byte_t       rx_data_i,
    input  logic        rx_den_i,
    input  logic        rx_eof_i,
    input  logic        link_up_i,
    frame_stream_if.src pay_o
);

    localparam int HDR_CNT_W = $clog2(`HDR_BYTES + 1);
    localparam int LAST = `FCS_BYTES - 1;

    byte_t                  in_data_q;
    logic                   in_den_q;
    logic                   in_eof_q;
    logic                   in_link_q;

    cut_state_t             state;
    logic [HDR_CNT_W-1:0]   hdr_cnt;
    logic                   drop_q;     // frame started with link down
    logic                   first_q;    // next body byte is first kept
    logic                   push;

    // fcs hold-back line
    byte_t                  sr_data [`FCS_BYTES];
    logic [`FCS_BYTES-1:0]  sr_vld;
    logic [`FCS_BYTES-1:0]  sr_sof;

    assign push = (state == CUT_BODY) && in_den_q;

    // input register stage
    always_ff @(posedge clk125M) begin
        in_data_q <= rx_data_i;
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            in_den_q  <= 1'b0;
            in_eof_q  <= 1'b0;
            in_link_q <= 1'b0;
        end else begin
            in_den_q  <= rx_den_i;
            in_eof_q  <= rx_den_i & rx_eof_i;
            in_link_q <= link_up_i;
        end
    end

    //----------------------------
    // frame tracking
    //----------------------------
    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            state   <= CUT_IDLE;
            hdr_cnt <= '0;
            drop_q  <= 1'b0;
            first_q <= 1'b0;
        end else begin
            case (state)
                CUT_IDLE: begin
                    if (in_den_q && !drop_q) begin
                        if (in_link_q && !in_eof_q) begin
                            state   <= CUT_HEAD;
                            hdr_cnt <= HDR_CNT_W'(1);   // byte 0 already seen
                        end else if (!in_link_q && !in_eof_q) begin
                            drop_q  <= 1'b1;
                        end
                    end else if (in_den_q && in_eof_q) begin
                        drop_q <= 1'b0;     // ignored frame is over
                    end
                end
                CUT_HEAD: begin
                    if (in_den_q) begin
                        hdr_cnt <= hdr_cnt + HDR_CNT_W'(1);
                        if (in_eof_q) begin
                            state <= CUT_IDLE;  // runt
                        end else if (hdr_cnt == HDR_CNT_W'(`HDR_BYTES - 1)) begin
                            state   <= CUT_BODY;
                            first_q <= 1'b1;
                        end
                    end
                end
                CUT_BODY: begin
                    if (in_den_q) begin
                        first_q <= 1'b0;
                        if (in_eof_q) begin
                            state <= CUT_IDLE;
                        end
                    end
                end
                default: begin
                    state <= CUT_IDLE;
                end
            endcase
        end
    end

    // a byte leaves only once FCS_BYTES newer bytes are behind it
    always_ff @(posedge clk125M) begin
        if (push) begin
            sr_data[0] <= in_data_q;
            for (int i = 1; i < `FCS_BYTES; i++) begin
                sr_data[i] <= sr_data[i-1];
            end
        end
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            sr_vld <= '0;
            sr_sof <= '0;
        end else if (push) begin
            if (in_eof_q) begin
                sr_vld <= '0;   // what remains is the fcs
                sr_sof <= '0;
            end else begin
                sr_vld <= {sr_vld[LAST-1:0], 1'b1};
                sr_sof <= {sr_sof[LAST-1:0], first_q};
            end
        end
    end

    // output register
    always_ff @(posedge clk125M) begin
        pay_o.data <= sr_data[LAST];
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            pay_o.valid <= 1'b0;
            pay_o.sof   <= 1'b0;
            pay_o.eof   <= 1'b0;
        end else begin
            pay_o.valid <= push & sr_vld[LAST];
            pay_o.sof   <= push & sr_sof[LAST];
            pay_o.eof   <= push & sr_vld[LAST] & in_eof_q;  // input eof closes the payload
        end
    end

endmodule

// ==== hw/uplink_port_select.sv ====
//----------------------------
// uplink port selector
// locks one port per frame by module_en and eth_num
//----------------------------
`timescale 1ns/1ps
`include "eth_uplink_config.svh"

module uplink_port_select import eth_uplink_pkg::*; (
    input  logic        clk125M,
    input  logic        rst_i,
    input  logic        module_en_i,
    input  port_t       eth_num_i,
    frame_stream_if.snk pay_i [`ETH_COUNT],
    frame_stream_if.src sel_o
);

    byte_t                  in_data [`ETH_COUNT];
    logic [`ETH_COUNT-1:0]  in_valid;
    logic [`ETH_COUNT-1:0]  in_sof;
    logic [`ETH_COUNT-1:0]  in_eof;

    sel_state_t             state;
    port_t                  cur_port;   // port locked for the current frame
    port_t                  src_port;
    logic                   start_sel;
    logic                   fwd;
    logic                   last;

    // flatten the interface array so it can be indexed at run time
    for (genvar p = 0; p < `ETH_COUNT; p++) begin : g_port
        assign in_data[p]  = pay_i[p].data;
        assign in_valid[p] = pay_i[p].valid;
        assign in_sof[p]   = pay_i[p].sof;
        assign in_eof[p]   = pay_i[p].eof;
    end

    //----------------------------
    // port choice
    //----------------------------
    always_comb begin
        src_port  = (state == SEL_IDLE) ? eth_num_i : cur_port;
        start_sel = (state == SEL_IDLE) && in_valid[eth_num_i] && in_sof[eth_num_i];
        fwd       = (start_sel && module_en_i) ||
                    ((state == SEL_PASS) && in_valid[cur_port]);
        last      = in_valid[src_port] && in_eof[src_port];
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            state    <= SEL_IDLE;
            cur_port <= '0;
        end else begin
            case (state)
                SEL_IDLE: begin
                    if (start_sel) begin
                        cur_port <= eth_num_i;
                        if (!last) begin    // single byte frame stays idle
                            state <= module_en_i ? SEL_PASS : SEL_DROP;
                        end
                    end
                end
                SEL_PASS, SEL_DROP: begin
                    if (last) begin
                        state <= SEL_IDLE;
                    end
                end
                default: begin
                    state <= SEL_IDLE;
                end
            endcase
        end
    end

    //----------------------------
    // output stage
    //----------------------------
    always_ff @(posedge clk125M) begin
        sel_o.data <= in_data[src_port];
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            sel_o.valid <= 1'b0;
            sel_o.sof   <= 1'b0;
            sel_o.eof   <= 1'b0;
        end else begin
            sel_o.valid <= fwd;
            sel_o.sof   <= fwd & in_sof[src_port];
            sel_o.eof   <= fwd & in_eof[src_port];
        end
    end

endmodule

// ==== hw/uplink_credit_tx.sv ====
//----------------------------
// uplink credit transmitter
// frame byte fifo released by credits
//----------------------------
`timescale 1ns/1ps
`include "eth_uplink_config.svh"

module uplink_credit_tx import eth_uplink_pkg::*; (
    input  logic        clk125M,
    input  logic        rst_i,
    frame_stream_if.snk sel_i,
    input  logic        up_credit_i,
    output byte_t       up_data_o,
    output logic        up_valid_o,
    output logic        up_sof_o,
    output logic        up_eof_o,
    output logic        overflow_o
);

    localparam int AW = $clog2(`FIFO_DEPTH);
    localparam int CW = $clog2(`CREDIT_MAX + 1);
    localparam int EW = `BYTE_W + 2;    // sof, eof, data

    logic [EW-1:0]  mem [`FIFO_DEPTH];
    logic [AW:0]    wr_ptr;     // extra msb tells full from empty
    logic [AW:0]    rd_ptr;
    logic [EW-1:0]  rd_word;
    logic           empty;
    logic           full;
    logic           wr_en;
    logic           rd_en;
    logic [CW-1:0]  credit_cnt; // credits held, spent while up_valid_o

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_en   = sel_i.valid && !full;
    assign rd_word = mem[rd_ptr[AW-1:0]];

    // the byte on the output still owns one credit
    assign rd_en   = !empty && (credit_cnt > CW'(up_valid_o));

    //----------------------------
    // fifo
    //----------------------------
    always_ff @(posedge clk125M) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {sel_i.sof, sel_i.eof, sel_i.data};
        end
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (sel_i.valid && full) begin
                overflow_o <= 1'b1;     // sticky until reset
            end
        end
    end

    //----------------------------
    // credits
    //----------------------------
    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            credit_cnt <= '0;
        end else begin
            case ({up_credit_i, up_valid_o})
                2'b10: begin
                    if (credit_cnt != CW'(`CREDIT_MAX)) begin
                        credit_cnt <= credit_cnt + CW'(1);
                    end
                end
                2'b01: begin
                    credit_cnt <= credit_cnt - CW'(1);
                end
                default: begin
                    credit_cnt <= credit_cnt;   // add and spend cancel
                end
            endcase
        end
    end

    // uplink output register
    always_ff @(posedge clk125M) begin
        if (rd_en) begin
            up_data_o <= rd_word[`BYTE_W-1:0];
        end
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            up_valid_o <= 1'b0;
            up_sof_o   <= 1'b0;
            up_eof_o   <= 1'b0;
        end else begin
            up_valid_o <= rd_en;
            up_sof_o   <= rd_en & rd_word[EW-1];
            up_eof_o   <= rd_en & rd_word[EW-2];
        end
    end

endmodule

// ==== hw/eth_uplink_top.sv ====
//----------------------------
// ethernet receive uplink
// per-port cutters, port selector and credit uplink
//----------------------------
`timescale 1ns/1ps
`include "eth_uplink_config.svh"

module eth_uplink_top import eth_uplink_pkg::*; (
    input  logic                            clk125M,
    input  logic                            rst_i,

    // mac receive side, one lane per port
    input  logic [`ETH_COUNT*`BYTE_W-1:0]   rx_data_i,
    input  logic [`ETH_COUNT-1:0]           rx_den_i,
    input  logic [`ETH_COUNT-1:0]           rx_eof_i,
    input  logic [`ETH_COUNT-1:0]           mac_link_i,

    // control
    input  logic                            module_en_i,
    input  port_t                           eth_num_i,

    // serial uplink
    input  logic                            up_credit_i,
    output byte_t                           up_data_o,
    output logic                            up_valid_o,
    output logic                            up_sof_o,
    output logic                            up_eof_o,
    output logic                            overflow_o
);

    frame_stream_if pay_if [`ETH_COUNT] ();    // cutter outputs
    frame_stream_if sel_if ();                 // selected stream

    //----------------------------
    // per-port payload cut
    //----------------------------
    for (genvar p = 0; p < `ETH_COUNT; p++) begin : g_eth
        rx_payload_cut u_cut (
            .clk125M   (clk125M),
            .rst_i     (rst_i),
            .rx_data_i (rx_data_i[p*`BYTE_W +: `BYTE_W]),
            .rx_den_i  (rx_den_i[p]),
            .rx_eof_i  (rx_eof_i[p]),
            .link_up_i (mac_link_i[p]),    // port gated by its link
            .pay_o     (pay_if[p])
        );
    end

    uplink_port_select u_sel (
        .clk125M     (clk125M),
        .rst_i       (rst_i),
        .module_en_i (module_en_i),
        .eth_num_i   (eth_num_i),
        .pay_i       (pay_if),
        .sel_o       (sel_if)
    );

    //----------------------------
    // uplink
    //----------------------------
    uplink_credit_tx u_tx (
        .clk125M     (clk125M),
        .rst_i       (rst_i),
        .sel_i       (sel_if),
        .up_credit_i (up_credit_i),
        .up_data_o   (up_data_o),
        .up_valid_o  (up_valid_o),
        .up_sof_o    (up_sof_o),
        .up_eof_o    (up_eof_o),
        .overflow_o  (overflow_o)
    );

endmodule

// ==== tests/eth_uplink_properties.sv ====
//----------------------------
// uplink transmitter checks
// credits, sticky overflow and frame flags
//----------------------------
`timescale 1ns/1ps
`include "eth_uplink_config.svh"

module eth_uplink_properties #(
    parameter int CW = $clog2(`CREDIT_MAX + 1)
) (
    input  logic            clk125M,
    input  logic            rst_i,
    input  logic            up_valid_i,
    input  logic            up_sof_i,
    input  logic            up_eof_i,
    input  logic            overflow_i,
    input  logic [CW-1:0]   credit_cnt_i
);

    logic in_frame;     // between an sof and its eof

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            in_frame <= 1'b0;
        end else if (up_valid_i && up_sof_i && !up_eof_i) begin
            in_frame <= 1'b1;
        end else if (up_valid_i && up_eof_i) begin
            in_frame <= 1'b0;
        end
    end

    a_credit_held: assert property (@(posedge clk125M) disable iff (rst_i)
        up_valid_i |-> (credit_cnt_i != '0))
        else $error("uplink byte sent while no credit was held");

    // only a reset may clear the flag
    a_overflow_sticky: assert property (@(posedge clk125M)
        (overflow_i && !rst_i) |=> overflow_i)
        else $error("overflow flag fell without a reset");

    a_sof_eof_order: assert property (@(posedge clk125M) disable iff (rst_i)
        (up_valid_i && up_sof_i) |-> !in_frame)
        else $error("uplink sof arrived before the eof of the open frame");

endmodule

bind uplink_credit_tx eth_uplink_properties u_props (
    .clk125M      (clk125M),
    .rst_i        (rst_i),
    .up_valid_i   (up_valid_o),
    .up_sof_i     (up_sof_o),
    .up_eof_i     (up_eof_o),
    .overflow_i   (overflow_o),
    .credit_cnt_i (credit_cnt)
);

// ==== tests/eth_uplink_tb.sv ====
//----------------------------
// uplink testbench
// table of frames, credit driver and byte scoreboard
//----------------------------
`timescale 1ns/1ps
`include "eth_uplink_config.svh"

module eth_uplink_tb import eth_uplink_pkg::*; ();

    localparam int N_TESTS   = 12;
    localparam int GAP       = 12;  // idle cycles after each frame
    localparam int CR_STEADY = 0;
    localparam int CR_BURSTY = 1;
    localparam int CR_NONE   = 2;

    typedef struct {
        string                  name;
        int                     port;
        int                     len;
        logic [`ETH_COUNT-1:0]  link;
        logic                   en;
        port_t                  num;
        port_t                  mid_num;    // eth_num set halfway through the frame
        int                     credit;
        logic                   has_out;
    } test_row_t;

    logic                           clk125M;
    logic                           rst_i;
    logic [`ETH_COUNT*`BYTE_W-1:0]  rx_data_i;
    logic [`ETH_COUNT-1:0]          rx_den_i;
    logic [`ETH_COUNT-1:0]          rx_eof_i;
    logic [`ETH_COUNT-1:0]          mac_link_i;
    logic                           module_en_i;
    port_t                          eth_num_i;
    logic                           up_credit_i;
    byte_t                          up_data_o;
    logic                           up_valid_o;
    logic                           up_sof_o;
    logic                           up_eof_o;
    logic                           overflow_o;

    test_row_t              rows [N_TESTS];
    byte_t                  frame_buf [256];
    logic [`BYTE_W+1:0]     exp_q [$];      // sof, eof, data
    logic [`BYTE_W+1:0]     exp_word;
    string                  cur_name;
    int                     seed;
    int                     err_cnt;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     credit_mode;
    int                     credit_held;    // own count of uplink credits
    int                     credit_next;
    int                     cycle_cnt;
    int                     cycle_limit;
    logic                   ovf_exp;
    logic [3:0]             burst_phase;

    eth_uplink_top dut (.*);

    always #4 clk125M = ~clk125M;

    //----------------------------
    // credit driver and credit count
    //----------------------------
    always @(posedge clk125M) begin
        burst_phase <= burst_phase + 4'd1;
        case (credit_mode)
            CR_STEADY: up_credit_i <= 1'b1;
            CR_BURSTY: up_credit_i <= (burst_phase < 4'd5);    // 5 of every 16
            default:   up_credit_i <= 1'b0;
        endcase
    end

    always @(posedge clk125M) begin
        if (rst_i) begin
            credit_held <= 0;
        end else begin
            assert (!up_valid_o || credit_held > 0) else begin
                $display("test %s: uplink sent a byte with no credit left", cur_name);
                err_cnt++;
            end
            credit_next = credit_held + int'(up_credit_i) - int'(up_valid_o);
            credit_held <= (credit_next > `CREDIT_MAX) ? `CREDIT_MAX : credit_next;
        end
    end

    // scoreboard
    always @(posedge clk125M) begin
        if (!rst_i && up_valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("test %s: uplink sent byte %h that no frame should give",
                         cur_name, up_data_o);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (up_data_o == exp_word[`BYTE_W-1:0]) else begin
                    $display("Mismatch %s data: expected %h, actual %h",
                             cur_name, exp_word[`BYTE_W-1:0], up_data_o);
                    err_cnt++;
                end
                assert (up_sof_o == exp_word[`BYTE_W+1]) else begin
                    $display("Mismatch %s sof: expected %b, actual %b",
                             cur_name, exp_word[`BYTE_W+1], up_sof_o);
                    err_cnt++;
                end
                assert (up_eof_o == exp_word[`BYTE_W]) else begin
                    $display("Mismatch %s eof: expected %b, actual %b",
                             cur_name, exp_word[`BYTE_W], up_eof_o);
                    err_cnt++;
                end
            end
        end
    end

    always @(posedge clk125M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles in test %s", cycle_cnt, cur_name);
            $display("Regression failed");
            $finish;
        end
    end

    //----------------------------
    // stimulus
    //----------------------------
    task load_table;
        rows[0]  = '{"sel_port0", 0, 40, 4'hf, 1'b1, port_t'(0), port_t'(0), CR_STEADY, 1'b1};
        rows[1]  = '{"other_port", 2, 30, 4'hf, 1'b1, port_t'(1), port_t'(1), CR_STEADY, 1'b0};
        rows[2]  = '{"module_off", 1, 30, 4'hf, 1'b0, port_t'(1), port_t'(1), CR_STEADY, 1'b0};
        rows[3]  = '{"link_down", 3, 30, 4'h7, 1'b1, port_t'(3), port_t'(3), CR_STEADY, 1'b0};
        rows[4]  = '{"switch_mid", 3, 48, 4'hf, 1'b1, port_t'(3), port_t'(0), CR_STEADY, 1'b1};
        rows[5]  = '{"old_port", 3, 30, 4'hf, 1'b1, port_t'(0), port_t'(0), CR_STEADY, 1'b0};
        rows[6]  = '{"new_port", 0, 30, 4'hf, 1'b1, port_t'(0), port_t'(0), CR_STEADY, 1'b1};
        rows[7]  = '{"bursty", 2, 60, 4'hf, 1'b1, port_t'(2), port_t'(2), CR_BURSTY, 1'b1};
        rows[8]  = '{"alt_port1", 1, 24, 4'hf, 1'b1, port_t'(1), port_t'(1), CR_STEADY, 1'b1};
        rows[9]  = '{"alt_port2", 2, 24, 4'hf, 1'b1, port_t'(2), port_t'(2), CR_STEADY, 1'b1};
        rows[10] = '{"alt_port1_min", 1, 13, 4'hf, 1'b1, port_t'(1), port_t'(1), CR_STEADY, 1'b1};
        rows[11] = '{"overflow", 0, 120, 4'hf, 1'b1, port_t'(0), port_t'(0), CR_NONE, 1'b1};
    endtask

    task send_frame(input int port, input int len, input port_t mid_num);
        for (int i = 0; i < len; i++) begin
            @(posedge clk125M);
            rx_data_i[port*`BYTE_W +: `BYTE_W] <= frame_buf[i];
            rx_den_i[port] <= 1'b1;
            rx_eof_i[port] <= (i == len - 1);
            if (i == len / 2) begin
                eth_num_i <= mid_num;
            end
        end
        @(posedge clk125M);
        rx_den_i[port] <= 1'b0;
        rx_eof_i[port] <= 1'b0;
    endtask

    task run_test(input int t);
        int held;
        int kept;
        int n_out;
        int first_err;
        first_err = err_cnt;
        cur_name  = rows[t].name;
        @(posedge clk125M);
        mac_link_i  <= rows[t].link;
        module_en_i <= rows[t].en;
        eth_num_i   <= rows[t].num;
        credit_mode <= rows[t].credit;
        repeat (2) @(posedge clk125M);  // credit line follows the new mode

        for (int i = 0; i < rows[t].len; i++) begin
            frame_buf[i] = byte_t'($random(seed));
        end

        // payload is what is left once header and fcs are cut
        held  = credit_held;
        kept  = rows[t].len - `HDR_BYTES - `FCS_BYTES;
        n_out = kept;
        if (rows[t].has_out) begin
            if (rows[t].credit == CR_NONE && kept > `FIFO_DEPTH + held) begin
                n_out   = `FIFO_DEPTH + held;   // tail lost to the full fifo
                ovf_exp = 1'b1;
            end
            for (int i = 0; i < n_out; i++) begin
                exp_q.push_back({(i == 0), (i == kept - 1), frame_buf[`HDR_BYTES + i]});
            end
        end

        send_frame(rows[t].port, rows[t].len, rows[t].mid_num);
        repeat (GAP) @(posedge clk125M);

        if (rows[t].credit == CR_NONE) begin
            assert (overflow_o == ovf_exp) else begin
                $display("Mismatch %s overflow_o before credits: expected %b, actual %b",
                         cur_name, ovf_exp, overflow_o);
                err_cnt++;
            end
            credit_mode <= CR_STEADY;
        end
        while (exp_q.size() != 0) begin
            @(posedge clk125M);
        end
        assert (overflow_o == ovf_exp) else begin
            $display("Mismatch %s overflow_o: expected %b, actual %b",
                     cur_name, ovf_exp, overflow_o);
            err_cnt++;
        end

        if (err_cnt == first_err) begin
            pass_cnt++;
            $display("test %0d %s: ok", t, cur_name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: FAILED with %0d errors", t, cur_name, err_cnt - first_err);
        end
    endtask

    initial begin
        clk125M     = 1'b0;
        rst_i       = 1'b1;
        rx_data_i   = '0;
        rx_den_i    = '0;
        rx_eof_i    = '0;
        mac_link_i  = '0;
        module_en_i = 1'b0;
        eth_num_i   = '0;
        up_credit_i = 1'b0;
        credit_mode = CR_NONE;
        burst_phase = 4'd0;
        seed        = 32'h44db;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cycle_cnt   = 0;
        ovf_exp     = 1'b0;
        cur_name    = "reset";
        load_table();

        cycle_limit = 200;
        for (int t = 0; t < N_TESTS; t++) begin
            cycle_limit += rows[t].len + GAP + `FIFO_DEPTH;
        end

        repeat (10) @(posedge clk125M);
        rst_i <= 1'b0;

        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 N_TESTS, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/eth_uplink_pkg.sv
hw/frame_stream_if.sv
hw/rx_payload_cut.sv
hw/uplink_port_select.sv
hw/uplink_credit_tx.sv
hw/eth_uplink_top.sv
tests/eth_uplink_properties.sv
tests/eth_uplink_tb.sv

// ==== Makefile ====
# Verilator build and run of the uplink testbench

VERILATOR ?= verilator
TOP       ?= eth_uplink_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
